// File: hdl/rv_pkg.sv
package rv_pkg;

  // --------------------
  // Widths and constants
  // --------------------

  localparam int XLEN = 32;

  // One data word or byte address
  typedef logic [XLEN-1:0] word_t;

  // Raw instruction word
  typedef logic [31:0] instr_t;

  // Register index, x0..x31
  typedef logic [4:0] reg_addr_t;

  localparam word_t RESET_PC = '0;

  // ADDI x0,x0,0 used as the bubble
  localparam instr_t I_NOP = 32'h0000_0013;
  localparam instr_t I_EBREAK = 32'h0010_0073;

  // Major opcodes in the supported subset
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL = 7'b1101111;

  // --------------------
  // Enums
  // --------------------

  // ADD comes first so an all-zero bubble decodes as an add
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    PASS_B
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_e;

  // Operand source in EX
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  // --------------------
  // Pipeline registers
  // --------------------

  typedef struct packed {
    instr_t instr;
    word_t  pc;
  } if_id_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    logic      branch_ne;
    logic      is_jump;
    logic      is_ebreak;
    logic      alu_b_imm;
    alu_op_e   alu_op;
    res_src_e  res_src;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    word_t     pc;
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_ebreak;
    res_src_e  res_src;
    reg_addr_t rd;
    word_t     alu_result;
    word_t     store_data;
    word_t     pc_plus4;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    logic      is_ebreak;
    reg_addr_t rd;
    word_t     rd_data;
  } mem_wb_t;

endpackage

// File: hdl/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   stall,
  input  logic   redirect,
  input  logic   flush,
  input  word_t  redirect_pc,
  output logic   imem_ren,
  output word_t  imem_raddr,
  input  instr_t imem_rdata,
  output if_id_t if_id
);

  word_t pc;
  word_t pc_next;

  // --------------------
  // PC
  // --------------------

  // Redirect from EX beats the sequential path
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc + word_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // SRAM answers in the same cycle
  assign imem_ren   = !stall;
  assign imem_raddr = pc;

  // --------------------
  // IF/ID register
  // --------------------

  // Stall wins over flush, so a flush seen here is always a redirect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id.instr <= I_NOP;
      if_id.pc    <= RESET_PC;
    end else if (stall) begin
      if_id <= if_id;
    end else if (flush) begin
      if_id.instr <= I_NOP;
      if_id.pc    <= pc;
    end else begin
      if_id.instr <= imem_rdata;
      if_id.pc    <= pc;
    end
  end

  // Branch and jump targets are built from aligned immediates
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      flush,
  input  if_id_t    if_id,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output logic      rs1_used,
  output logic      rs2_used,
  output id_ex_t    id_ex
);

  instr_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  id_ex_t     dec;

  assign instr  = if_id.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Register fields sit in the same place for every format
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  // --------------------
  // Immediates
  // --------------------

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------
  // Control decode
  // --------------------

  // Anything outside the subset falls through as a NOP
  always_comb begin
    dec      = '0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;

    case (opcode)
      OPC_OP: begin
        rs1_used      = 1'b1;
        rs2_used      = 1'b1;
        dec.reg_write = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = funct7[5] ? SUB : ADD;
          3'b111:  dec.alu_op = AND;
          3'b110:  dec.alu_op = OR;
          3'b100:  dec.alu_op = XOR;
          3'b010:  dec.alu_op = SLT;
          default: dec.reg_write = 1'b0;
        endcase
      end

      // Only ADDI
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          rs1_used      = 1'b1;
          dec.reg_write = 1'b1;
          dec.alu_b_imm = 1'b1;
          dec.imm       = imm_i;
        end
      end

      OPC_LUI: begin
        dec.reg_write = 1'b1;
        dec.alu_b_imm = 1'b1;
        dec.alu_op    = PASS_B;
        dec.imm       = imm_u;
      end

      // Word access only
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          rs1_used      = 1'b1;
          dec.reg_write = 1'b1;
          dec.mem_read  = 1'b1;
          dec.alu_b_imm = 1'b1;
          dec.res_src   = RES_MEM;
          dec.imm       = imm_i;
        end
      end

      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          rs1_used      = 1'b1;
          rs2_used      = 1'b1;
          dec.mem_write = 1'b1;
          dec.alu_b_imm = 1'b1;
          dec.imm       = imm_s;
        end
      end

      // BEQ and BNE differ only in funct3[0]
      OPC_BRANCH: begin
        if (funct3[2:1] == 2'b00) begin
          rs1_used      = 1'b1;
          rs2_used      = 1'b1;
          dec.is_branch = 1'b1;
          dec.branch_ne = funct3[0];
          dec.imm       = imm_b;
        end
      end

      // Link value is PC+4
      OPC_JAL: begin
        dec.reg_write = 1'b1;
        dec.is_jump   = 1'b1;
        dec.res_src   = RES_PC4;
        dec.imm       = imm_j;
      end

      default: begin
        dec.is_ebreak = (instr == I_EBREAK);
      end
    endcase

    dec.rd       = instr[11:7];
    dec.rs1      = rs1;
    dec.rs2      = rs2;
    dec.rs1_data = rs1_data;
    dec.rs2_data = rs2_data;
    dec.pc       = if_id.pc;
  end

  // --------------------
  // ID/EX register
  // --------------------

  // All-zero is a bubble with every write disabled
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      id_ex <= '0;
    end else begin
      id_ex <= dec;
    end
  end

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  mem_wb_t   wb
);

  // x1..x31, x0 has no storage
  word_t regs [1:31];

  logic  wr_en;

  assign wr_en = wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wb.rd] <= wb.rd_data;
    end
  end

  // Same-cycle write is passed straight through to the reader
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wr_en && (wb.rd == rs1)) ? wb.rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wr_en && (wb.rd == rs2)) ? wb.rd_data : regs[rs2];

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  id_ex_t  id_ex,
  output ex_mem_t ex_mem,
  input  mem_wb_t wb,
  output logic    redirect,
  output word_t   redirect_pc
);

  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  word_t    mem_val;
  word_t    rs1_fwd;
  word_t    rs2_fwd;
  word_t    alu_b;
  word_t    alu_result;
  word_t    pc_plus4;
  logic     branch_taken;

  // --------------------
  // Forwarding
  // --------------------

  // MEM is younger than WB, so it is checked first
  function automatic fwd_sel_e fwd_select(reg_addr_t rs, ex_mem_t m, mem_wb_t w);
    if (m.reg_write && (m.rd != '0) && (m.rd == rs)) begin
      return FWD_MEM;
    end else if (w.reg_write && (w.rd != '0) && (w.rd == rs)) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf, word_t m, word_t w);
    case (sel)
      FWD_MEM: return m;
      FWD_WB:  return w;
      default: return rf;
    endcase
  endfunction

  // A JAL in MEM forwards its link value
  // Loads never get here because of the load-use stall
  assign mem_val = (ex_mem.res_src == RES_PC4) ? ex_mem.pc_plus4 : ex_mem.alu_result;

  assign fwd_a   = fwd_select(id_ex.rs1, ex_mem, wb);
  assign fwd_b   = fwd_select(id_ex.rs2, ex_mem, wb);
  assign rs1_fwd = fwd_mux(fwd_a, id_ex.rs1_data, mem_val, wb.rd_data);
  assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_data, mem_val, wb.rd_data);

  // --------------------
  // ALU
  // --------------------

  assign alu_b = id_ex.alu_b_imm ? id_ex.imm : rs2_fwd;

  always_comb begin
    case (id_ex.alu_op)
      SUB:     alu_result = rs1_fwd - alu_b;
      AND:     alu_result = rs1_fwd & alu_b;
      OR:      alu_result = rs1_fwd | alu_b;
      XOR:     alu_result = rs1_fwd ^ alu_b;
      SLT:     alu_result = {{(XLEN-1){1'b0}}, $signed(rs1_fwd) < $signed(alu_b)};
      PASS_B:  alu_result = alu_b;
      default: alu_result = rs1_fwd + alu_b;
    endcase
  end

  // --------------------
  // Branch resolution
  // --------------------

  // BNE inverts the equality result
  assign branch_taken = id_ex.is_branch && ((rs1_fwd == rs2_fwd) ^ id_ex.branch_ne);
  assign redirect     = branch_taken || id_ex.is_jump;
  assign redirect_pc  = id_ex.pc + id_ex.imm;
  assign pc_plus4     = id_ex.pc + word_t'(4);

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.mem_read   <= id_ex.mem_read;
      ex_mem.mem_write  <= id_ex.mem_write;
      ex_mem.is_ebreak  <= id_ex.is_ebreak;
      ex_mem.res_src    <= id_ex.res_src;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= rs2_fwd;
      ex_mem.pc_plus4   <= pc_plus4;
    end
  end

  // Decode never marks a branch or jump as EBREAK
  a_no_redirect_ebreak: assert property (
    @(posedge clk) disable iff (!rst_n) !(redirect && id_ex.is_ebreak)
  );

endmodule

// File: hdl/rv_memwb.sv
`timescale 1ns/1ps

module rv_memwb import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  ex_mem_t ex_mem,
  output logic    dmem_ren,
  output logic    dmem_we,
  output word_t   dmem_raddr,
  output word_t   dmem_waddr,
  output word_t   dmem_wdata,
  input  word_t   dmem_rdata,
  output mem_wb_t mem_wb,
  output logic    ebreak
);

  word_t wb_val;

  // --------------------
  // Data memory
  // --------------------

  // Address comes from the ALU for both loads and stores
  assign dmem_ren   = ex_mem.mem_read;
  assign dmem_raddr = ex_mem.alu_result;
  assign dmem_we    = ex_mem.mem_write;
  assign dmem_waddr = ex_mem.alu_result;
  assign dmem_wdata = ex_mem.store_data;

  // Write-back select, load data is valid this cycle
  always_comb begin
    case (ex_mem.res_src)
      RES_MEM: wb_val = dmem_rdata;
      RES_PC4: wb_val = ex_mem.pc_plus4;
      default: wb_val = ex_mem.alu_result;
    endcase
  end

  // --------------------
  // MEM/WB register
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.is_ebreak <= ex_mem.is_ebreak;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.rd_data   <= wb_val;
    end
  end

  // One pulse per EBREAK reaching WB
  assign ebreak = mem_wb.is_ebreak;

  // Load and store are decoded from distinct opcodes
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(dmem_ren && dmem_we));

endmodule

// File: hdl/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard import rv_pkg::*; (
  input  id_ex_t    id_ex,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      rs1_used,
  input  logic      rs2_used,
  input  logic      redirect,
  output logic      stall,
  output logic      flush
);

  logic load_in_ex;
  logic rs1_hit;
  logic rs2_hit;

  // Load result is only ready after MEM, so forwarding can't cover it
  assign load_in_ex = id_ex.mem_read && (id_ex.rd != '0);

  // Only sources the ID instruction really reads
  assign rs1_hit = rs1_used && (rs1 == id_ex.rd);
  assign rs2_hit = rs2_used && (rs2 == id_ex.rd);

  // One-cycle hold of PC and IF/ID
  assign stall = load_in_ex && (rs1_hit || rs2_hit);

  // Bubble into ID/EX for both a stall and a redirect
  // Fetch only clears IF/ID when stall is low
  assign flush = redirect || stall;

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,

  // Instruction memory, read only
  output logic   imem_ren,
  output word_t  imem_raddr,
  input  instr_t imem_rdata,

  // Data memory read side
  output logic   dmem_ren,
  output word_t  dmem_raddr,
  input  word_t  dmem_rdata,

  // Data memory write side, full words only
  output logic   dmem_we,
  output word_t  dmem_waddr,
  output word_t  dmem_wdata,

  output logic   ebreak
);

  // Stage-to-stage registers
  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;

  // ID register reads and hazard inputs
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rs1_used;
  logic      rs2_used;
  word_t     rs1_data;
  word_t     rs2_data;

  // Control
  logic      stall;
  logic      flush;
  logic      redirect;
  word_t     redirect_pc;

  rv_fetch u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .redirect   (redirect),
    .flush      (flush),
    .redirect_pc(redirect_pc),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .if_id      (if_id)
  );

  rv_decode u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush   (flush),
    .if_id   (if_id),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_used(rs1_used),
    .rs2_used(rs2_used),
    .id_ex   (id_ex)
  );

  // Written from WB, read from ID
  rv_regfile u_regfile (
    .clk     (clk),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wb      (mem_wb)
  );

  rv_execute u_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_ex      (id_ex),
    .ex_mem     (ex_mem),
    .wb         (mem_wb),
    .redirect   (redirect),
    .redirect_pc(redirect_pc)
  );

  rv_memwb u_memwb (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_mem    (ex_mem),
    .dmem_ren  (dmem_ren),
    .dmem_we   (dmem_we),
    .dmem_raddr(dmem_raddr),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .mem_wb    (mem_wb),
    .ebreak    (ebreak)
  );

  rv_hazard u_hazard (
    .id_ex   (id_ex),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_used(rs1_used),
    .rs2_used(rs2_used),
    .redirect(redirect),
    .stall   (stall),
    .flush   (flush)
  );

endmodule

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

  localparam int TIMEOUT   = 200;
  localparam int QUIET     = 20;
  localparam int N_TESTS   = 16;
  localparam int MEM_WORDS = 64;

  // Store offsets from x0, one per program kind
  localparam logic [11:0] ADDR_ALU  = 12'h040;
  localparam logic [11:0] ADDR_LD   = 12'h080;
  localparam logic [11:0] ADDR_LD2  = 12'h084;
  localparam logic [11:0] ADDR_BR   = 12'h0c0;
  localparam logic [11:0] ADDR_JAL  = 12'h0d0;
  localparam logic [11:0] ADDR_LUI  = 12'h0e0;
  localparam logic [11:0] BR_SKIP   = 12'h011;
  localparam logic [11:0] BR_FALL   = 12'h022;
  localparam int          JAL_PC    = 4;

  typedef enum logic [3:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_LOAD_USE, K_BEQ, K_BNE, K_JAL, K_LUI
  } test_kind_e;

  // One table row
  typedef struct packed {
    test_kind_e  kind;
    logic [11:0] a;
    logic [11:0] b;
    word_t       expected;
  } test_entry_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        imem_ren;
  word_t       imem_raddr;
  instr_t      imem_rdata;
  logic        dmem_ren;
  word_t       dmem_raddr;
  word_t       dmem_rdata;
  logic        dmem_we;
  word_t       dmem_waddr;
  word_t       dmem_wdata;
  logic        ebreak;

  instr_t      imem [MEM_WORDS];
  word_t       dmem [MEM_WORDS];
  instr_t      prog [MEM_WORDS];
  int          prog_len;
  test_entry_t tests [N_TESTS];
  integer      seed;
  int          stall_cycles;
  reg_addr_t   stall_rd;
  int          ebreak_count;
  int          hold_cycles;
  int          load_count;
  word_t       load_addr;
  int          sample_count;
  word_t       first_fetch;

  always #5 clk = ~clk;

  // --------------------
  // Memory models
  // --------------------

  // Zero-latency SRAMs, word indexed
  assign imem_rdata = imem[imem_raddr[7:2]];
  assign dmem_rdata = dmem[dmem_raddr[7:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_waddr[7:2]] <= dmem_wdata;
    end
  end

  rv_core u_rv_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_ren  (imem_ren),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .ebreak    (ebreak)
  );

  // --------------------
  // Encoders
  // --------------------

  function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic instr_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic instr_t enc_u(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic instr_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // R-type funct7/funct3 per ISA table
  function automatic instr_t enc_alu(test_kind_e kind, reg_addr_t rd, reg_addr_t rs1,
                                     reg_addr_t rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = 7'b0000000;
    case (kind)
      K_SUB: begin
        f7 = 7'b0100000;
        f3 = 3'b000;
      end
      K_AND:   f3 = 3'b111;
      K_OR:    f3 = 3'b110;
      K_XOR:   f3 = 3'b100;
      K_SLT:   f3 = 3'b010;
      default: f3 = 3'b000;
    endcase
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Unused imem words are harmless ADDI x0 with the word index as immediate
  function automatic instr_t imem_fill(int idx);
    return enc_i(idx[11:0], 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
  endfunction

  function automatic word_t dmem_fill(int idx);
    return 32'hd0d0_0000 | word_t'(idx * 4);
  endfunction

  // Result the final store must carry, from the RV32I rules
  function automatic word_t expected_value(test_entry_t e);
    word_t a;
    word_t b;
    a = sext12(e.a);
    b = sext12(e.b);
    case (e.kind)
      K_ADD:      return a + b;
      K_SUB:      return a - b;
      K_AND:      return a & b;
      K_OR:       return a | b;
      K_XOR:      return a ^ b;
      K_SLT:      return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
      K_LOAD_USE: return a + b;
      K_BEQ:      return (a == b) ? sext12(BR_SKIP) : sext12(BR_FALL);
      K_BNE:      return (a != b) ? sext12(BR_SKIP) : sext12(BR_FALL);
      K_JAL:      return word_t'(JAL_PC + 4);
      default:    return {e.a, e.b[7:0], 12'h000};
    endcase
  endfunction

  // --------------------
  // Checks
  // --------------------

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      fail_stop($sformatf("[FAIL] %0t %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      fail_stop($sformatf("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_stop($sformatf("[FAIL] %0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  // --------------------
  // Program and run
  // --------------------

  task automatic emit(input instr_t i);
    prog[prog_len] = i;
    prog_len++;
  endtask

  task automatic add_entry(input int idx, input test_kind_e kind, input logic same);
    test_entry_t e;
    int r;
    e.kind = kind;
    r = $random(seed);
    e.a = r[11:0];
    r = $random(seed);
    e.b = same ? e.a : r[11:0];
    e.expected = expected_value(e);
    tests[idx] = e;
  endtask

  // Every program ends with EBREAK and a JAL-to-self
  task automatic build_program(input test_entry_t e);
    prog_len = 0;
    case (e.kind)
      K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT: begin
        emit(enc_i(e.a, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        emit(enc_i(e.b, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        emit(enc_alu(e.kind, 5'd3, 5'd1, 5'd2));
        emit(enc_s(ADDR_ALU, 5'd3, 5'd0));
      end
      // ADDI right behind LW needs the one-cycle stall
      K_LOAD_USE: begin
        emit(enc_i(e.a, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        emit(enc_s(ADDR_LD, 5'd1, 5'd0));
        emit(enc_i(ADDR_LD, 5'd0, 3'b010, 5'd2, OPC_LOAD));
        emit(enc_i(e.b, 5'd2, 3'b000, 5'd3, OPC_OP_IMM));
        emit(enc_s(ADDR_LD2, 5'd3, 5'd0));
      end
      // Taken branch skips the ADDI that overwrites x3
      K_BEQ, K_BNE: begin
        emit(enc_i(BR_SKIP, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
        emit(enc_i(e.a, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        emit(enc_i(e.b, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, (e.kind == K_BNE) ? 3'b001 : 3'b000));
        emit(enc_i(BR_FALL, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
        emit(enc_s(ADDR_BR, 5'd3, 5'd0));
      end
      K_JAL: begin
        emit(enc_i(e.a, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
        emit(enc_j(21'd12, 5'd5));
        emit(enc_s(ADDR_ALU, 5'd6, 5'd0));
        emit(enc_s(ADDR_LD, 5'd6, 5'd0));
        emit(enc_s(ADDR_JAL, 5'd5, 5'd0));
      end
      default: begin
        emit(enc_u({e.a, e.b[7:0]}, 5'd4));
        emit(enc_s(ADDR_LUI, 5'd4, 5'd0));
      end
    endcase
    emit(I_EBREAK);
    emit(enc_j(21'd0, 5'd0));
  endtask

  // Loads both memories while reset is held for three edges
  task automatic load_and_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] <= (i < prog_len) ? prog[i] : imem_fill(i);
      dmem[i] <= dmem_fill(i);
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    stall_cycles = 0;
    stall_rd = '0;
    ebreak_count = 0;
    hold_cycles = 0;
    load_count = 0;
    load_addr = '0;
    sample_count = 0;
    first_fetch = '0;
  endtask

  // Outputs are sampled mid-cycle, away from the driving edge
  task automatic sample_cycle();
    @(negedge clk);
    if (sample_count == 0) begin
      first_fetch = imem_raddr;
    end
    sample_count++;
    if (!imem_ren) begin
      hold_cycles++;
    end
    if (dmem_ren) begin
      load_count++;
      load_addr = dmem_raddr;
    end
    if (u_rv_core.stall) begin
      stall_cycles++;
      stall_rd = u_rv_core.id_ex.rd;
    end
    if (ebreak) begin
      ebreak_count++;
    end
  endtask

  task automatic wait_for_store(output word_t addr, output word_t data);
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < TIMEOUT) begin
      sample_cycle();
      if (dmem_we) begin
        seen = 1'b1;
        addr = dmem_waddr;
        data = dmem_wdata;
      end
      n++;
    end
    if (!seen) begin
      fail_stop("Timed out waiting for a store on the data memory port");
    end
  endtask

  task automatic wait_for_ebreak();
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < TIMEOUT) begin
      sample_cycle();
      seen = ebreak;
      n++;
    end
    if (!seen) begin
      fail_stop("Timed out waiting for the ebreak pulse");
    end
  endtask

  task automatic run_test(input test_entry_t e);
    word_t addr;
    word_t data;
    case (e.kind)
      K_LOAD_USE: begin
        wait_for_store(addr, data);
        check_word("dmem_waddr", sext12(ADDR_LD), addr);
        check_word("dmem_wdata", sext12(e.a), data);
        wait_for_store(addr, data);
        check_word("dmem_waddr", sext12(ADDR_LD2), addr);
        check_word("dmem_wdata", e.expected, data);
        // The LW reads back the word the first SW wrote
        check_flag("single dmem_ren", 1'b1, load_count == 1);
        check_word("dmem_raddr", sext12(ADDR_LD), load_addr);
        check_flag("imem_ren low for one cycle", 1'b1, hold_cycles == 1);
        check_flag("single stall cycle", 1'b1, stall_cycles == 1);
        check_reg_addr("id_ex.rd during stall", 5'd2, stall_rd);
      end
      K_LUI: begin
        wait_for_store(addr, data);
        check_word("dmem_waddr", sext12(ADDR_LUI), addr);
        check_word("dmem_wdata", e.expected, data);
        check_flag("no dmem_ren", 1'b0, load_count != 0);
        check_flag("imem_ren held high", 1'b0, hold_cycles != 0);
      end
      default: begin
        wait_for_store(addr, data);
        case (e.kind)
          K_BEQ, K_BNE: check_word("dmem_waddr", sext12(ADDR_BR), addr);
          K_JAL:        check_word("dmem_waddr", sext12(ADDR_JAL), addr);
          default:      check_word("dmem_waddr", sext12(ADDR_ALU), addr);
        endcase
        check_word("dmem_wdata", e.expected, data);
        check_flag("no dmem_ren", 1'b0, load_count != 0);
        check_flag("imem_ren held high", 1'b0, hold_cycles != 0);
        check_flag("no stall", 1'b0, stall_cycles != 0);
      end
    endcase
    wait_for_ebreak();
    // First fetch after reset is the reset vector
    check_word("imem_raddr", RESET_PC, first_fetch);
    // Only the JAL-to-self loop runs after EBREAK
    if (e.kind == K_LUI) begin
      for (int q = 0; q < QUIET; q++) begin
        sample_cycle();
        check_flag("dmem_we", 1'b0, dmem_we);
      end
      check_flag("single ebreak pulse", 1'b1, ebreak_count == 1);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    seed  = 55193;
    prog_len = 0;
    stall_cycles = 0;
    stall_rd = '0;
    ebreak_count = 0;
    hold_cycles = 0;
    load_count = 0;
    load_addr = '0;
    sample_count = 0;
    first_fetch = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = imem_fill(i);
      dmem[i] = dmem_fill(i);
    end

    // Test table
    add_entry(0, K_ADD, 1'b0);
    add_entry(1, K_SUB, 1'b0);
    add_entry(2, K_AND, 1'b0);
    add_entry(3, K_OR, 1'b0);
    add_entry(4, K_XOR, 1'b0);
    add_entry(5, K_SLT, 1'b0);
    add_entry(6, K_SLT, 1'b0);
    add_entry(7, K_LOAD_USE, 1'b0);
    add_entry(8, K_BEQ, 1'b1);
    add_entry(9, K_BEQ, 1'b0);
    add_entry(10, K_BNE, 1'b1);
    add_entry(11, K_BNE, 1'b0);
    add_entry(12, K_JAL, 1'b0);
    add_entry(13, K_LUI, 1'b0);
    add_entry(14, K_ADD, 1'b0);
    add_entry(15, K_LOAD_USE, 1'b0);

    for (int i = 0; i < N_TESTS; i++) begin
      build_program(tests[i]);
      load_and_reset();
      run_test(tests[i]);
    end

    $display("sim passed");
    $finish;
  end

endmodule

// File: verilog.f
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_memwb.sv
hdl/rv_hazard.sv
hdl/rv_core.sv
verif/rv_core_tb.sv
